/* tb.f */
usibPkg.sv
usibRouter.sv
usibCmdDecode.sv
usibCsrBank.sv
usibTop.sv
usibTop_asserts.sv
tb_usibTop.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_usibTop \
	--Mdir obj_dir \
	-f tb.f

./obj_dir/Vtb_usibTop 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "RESULT: FAIL"
	exit 1
fi
echo "RESULT: PASS"

/* tb_usibTop.sv */
`default_nettype none

module tb_usibTop;
	import usibPkg::*;

	// --------------------------------------------------
	// Timing and watchdog budget
	// --------------------------------------------------
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	localparam int REGS         = BLOCK_NUM * CSR_DEPTH;	// All registers of all banks
	localparam int RD_CYCLES    = READ_LATENCY + 1;	// Issue edge plus latency
	localparam int WR_CYCLES    = 2;	// Issue edge plus idle edge
	localparam int BURST_LEN    = 8;
	localparam int SWEEP_CYCLES = REGS * RD_CYCLES;	// Read back of every register
	localparam int TEST_CYCLES  = SWEEP_CYCLES
		+ REGS * WR_CYCLES + SWEEP_CYCLES	// Masked writes
		+ 2 * SWEEP_CYCLES	// Write-read then read
		+ BURST_LEN + READ_LATENCY + 1
		+ 6 * RD_CYCLES + 2 * WR_CYCLES + SWEEP_CYCLES	// Out of range
		+ BLOCK_NUM * WR_CYCLES + SWEEP_CYCLES;	// Idle command
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

	logic      iSCLK;
	logic      iSRST;
	usibWord_t iMUsiAdrs;
	usibWord_t iMUsiWd;
	usibWord_t oMUsiRd;

	usibWord_t model [BLOCK_NUM][CSR_DEPTH];	// Expected bank contents, index 0 unused
	integer    seed;
	int        errorCount;
	int        checkCount;
	int        testCount;

	usibTop usibTop_i (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iMUsiAdrs (iMUsiAdrs),
		.iMUsiWd   (iMUsiWd),
		.oMUsiRd   (oMUsiRd)
	);

	always #(CLK_PERIOD / 2) iSCLK = ~iSCLK;

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic usibWord_t makeCmd(usibCmd_t cmd, blockAdrs_t blk, csrAdrs_t adrs);
		usibWord_t word;
		word = '0;
		word[CMD_MSB:CMD_LSB]                  = cmd;
		word[BLOCK_LSB +: BLOCK_ADRS_WIDTH]    = blk;
		word[CSR_ADRS_WIDTH-1:0]               = adrs;
		return word;
	endfunction

	function automatic usibWord_t expectedWord(int blk, int idx);
		if (idx == 0)
			return CSR_ID_BASE + usibWord_t'(blk);	// Identity
		return model[blk][idx];
	endfunction

	// Only writable bits follow the new data
	task automatic modelWrite(int blk, int idx, usibWord_t data);
		model[blk][idx] = (model[blk][idx] & ~CSR_WRITE_MASK[idx])
			| (data & CSR_WRITE_MASK[idx]);
	endtask

	task automatic checkWord(usibWord_t got, usibWord_t exp, string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One-cycle command strobe, then idle
	task automatic issueCmd(usibWord_t adrs, usibWord_t data);
		@(posedge iSCLK);
		iMUsiAdrs <= adrs;
		iMUsiWd   <= data;
		@(posedge iSCLK);
		iMUsiAdrs <= '0;
		iMUsiWd   <= '0;
	endtask

	task automatic doWrite(blockAdrs_t blk, csrAdrs_t adrs, usibWord_t data);
		issueCmd(makeCmd(CMD_WRITE, blk, adrs), data);
	endtask

	// Fixed latency, sampled mid-cycle
	task automatic waitRead(output usibWord_t got);
		repeat (READ_LATENCY - 1) @(posedge iSCLK);
		@(negedge iSCLK);
		got = oMUsiRd;
	endtask

	task automatic doRead(blockAdrs_t blk, csrAdrs_t adrs, output usibWord_t got);
		issueCmd(makeCmd(CMD_READ, blk, adrs), '0);
		waitRead(got);
	endtask

	task automatic doWriteRead(blockAdrs_t blk, csrAdrs_t adrs, usibWord_t data,
		output usibWord_t got);
		issueCmd(makeCmd(CMD_WRITE_READ, blk, adrs), data);
		waitRead(got);
	endtask

	task automatic readBackAll(string tag);
		usibWord_t got;
		for (int b = 0; b < BLOCK_NUM; b++)
		begin
			for (int i = 0; i < CSR_DEPTH; i++)
			begin
				doRead(blockAdrs_t'(b), csrAdrs_t'(i), got);
				checkWord(got, expectedWord(b, i),
					$sformatf("%s block %0d reg %0d", tag, b, i));
			end
		end
	endtask

	task automatic reportTest(string name, int errsBefore);
		testCount++;
		$display("Test %s finished with %0d errors", name, errorCount - errsBefore);
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic testResetValues();
		int errs;
		errs = errorCount;
		readBackAll("reset");	// Model is all zero here
		reportTest("reset values", errs);
	endtask

	task automatic testMaskedWrites();
		int        errs;
		usibWord_t data;
		errs = errorCount;
		for (int b = 0; b < BLOCK_NUM; b++)
		begin
			for (int i = 0; i < CSR_DEPTH; i++)
			begin
				data = $random(seed);
				doWrite(blockAdrs_t'(b), csrAdrs_t'(i), data);
				modelWrite(b, i, data);	// Index 0 mask is empty
			end
		end
		readBackAll("masked");
		reportTest("masked writes", errs);
	endtask

	task automatic testWriteRead();
		int        errs;
		usibWord_t data;
		usibWord_t got;
		errs = errorCount;
		for (int b = 0; b < BLOCK_NUM; b++)
		begin
			for (int i = 0; i < CSR_DEPTH; i++)
			begin
				data = $random(seed);
				doWriteRead(blockAdrs_t'(b), csrAdrs_t'(i), data, got);
				checkWord(got, expectedWord(b, i),
					$sformatf("write-read old block %0d reg %0d", b, i));
				modelWrite(b, i, data);
				doRead(blockAdrs_t'(b), csrAdrs_t'(i), got);
				checkWord(got, expectedWord(b, i),
					$sformatf("write-read new block %0d reg %0d", b, i));
			end
		end
		reportTest("write-read", errs);
	endtask

	task automatic testBurstReads();
		int        errs;
		usibWord_t expWords [BURST_LEN];
		usibWord_t prevRd;
		errs = errorCount;
		for (int j = 0; j < BURST_LEN; j++)
			expWords[j] = expectedWord(j % BLOCK_NUM, j / BLOCK_NUM);
		prevRd = oMUsiRd;	// Held until first burst word lands
		for (int i = 0; i < BURST_LEN + READ_LATENCY; i++)
		begin
			@(posedge iSCLK);
			if (i < BURST_LEN)
				iMUsiAdrs <= makeCmd(CMD_READ, blockAdrs_t'(i % BLOCK_NUM),
					csrAdrs_t'(i / BLOCK_NUM));
			else
				iMUsiAdrs <= '0;
			@(negedge iSCLK);
			if (i >= READ_LATENCY)
				checkWord(oMUsiRd, expWords[i - READ_LATENCY],
					$sformatf("burst word %0d", i - READ_LATENCY));
			else
				checkWord(oMUsiRd, prevRd, "burst before first word");
		end
		reportTest("back-to-back reads", errs);
	endtask

	task automatic testOutOfRange();
		int        errs;
		usibWord_t got;
		errs = errorCount;
		doRead(blockAdrs_t'(BLOCK_NUM), 16'd1, got);
		checkWord(got, '0, "read of missing block");
		doRead(5'd31, 16'd2, got);
		checkWord(got, '0, "read of block 31");
		doRead(5'd0, csrAdrs_t'(CSR_DEPTH), got);
		checkWord(got, '0, "read past bank");
		doRead(5'd1, 16'h0101, got);	// Low bits alias register 1
		checkWord(got, '0, "read far past bank");
		// Nonzero word on the return path first
		doRead(5'd0, 16'd0, got);
		checkWord(got, expectedWord(0, 0), "identity before missing block write");
		doWrite(blockAdrs_t'(BLOCK_NUM), 16'd1, $random(seed));
		waitRead(got);	// Missing block clears the read word
		checkWord(got, '0, "read word after write to missing block");
		doWrite(5'd0, 16'd9, $random(seed));
		doWrite(5'd2, 16'h8003, $random(seed));
		readBackAll("after out of range");	// Model unchanged
		reportTest("out of range", errs);
	endtask

	task automatic testIdleCmd();
		int errs;
		errs = errorCount;
		for (int b = 0; b < BLOCK_NUM; b++)
			issueCmd(makeCmd(CMD_NONE, blockAdrs_t'(b), csrAdrs_t'(b + 1)), $random(seed));
		readBackAll("after idle");
		reportTest("idle command", errs);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		iSCLK      = 1'b0;
		iSRST      = 1'b1;
		iMUsiAdrs  = '0;
		iMUsiWd    = '0;
		seed       = 42889;
		errorCount = 0;
		checkCount = 0;
		testCount  = 0;
		for (int b = 0; b < BLOCK_NUM; b++)
			for (int i = 0; i < CSR_DEPTH; i++)
				model[b][i] = '0;
		repeat (RESET_CYCLES) @(posedge iSCLK);
		iSRST <= 1'b0;
		testResetValues();
		testMaskedWrites();
		testWriteRead();
		testBurstReads();
		testOutOfRange();
		testIdleCmd();
		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* usibTop_asserts.sv */
`default_nettype none

module usibTop_asserts (
	input wire logic               iSCLK,
	input wire logic               iSRST,
	input wire usibPkg::usibWord_t iMUsiAdrs,	// Router input from master
	input wire usibPkg::usibWord_t oSUsiAdrs,	// Forwarded command
	input wire usibPkg::usibWord_t oMUsiRd
);
	import usibPkg::*;

	// Forward register idles right after reset
	resetIdle: assert property (@(posedge iSCLK)
		$past(iSRST) |-> oSUsiAdrs[CMD_MSB:CMD_LSB] == CMD_NONE)
		else $error("oSUsiAdrs command field not idle after reset");

	// One register stage, no change of the word
	forwardWord: assert property (@(posedge iSCLK) disable iff (iSRST)
		!$past(iSRST) |-> oSUsiAdrs == $past(iMUsiAdrs))
		else $error("oSUsiAdrs differs from last cycle's master command");

	// Missing block returns zero
	missingBlock: assert property (@(posedge iSCLK) disable iff (iSRST)
		$past(iMUsiAdrs[BLOCK_LSB +: BLOCK_ADRS_WIDTH], READ_LATENCY)
			>= blockAdrs_t'(BLOCK_NUM) |-> oMUsiRd == '0)
		else $error("oMUsiRd not zero after a command to a missing block");

endmodule

bind usibRouter usibTop_asserts routerAsserts_i (
	.iSCLK     (iSCLK),
	.iSRST     (iSRST),
	.iMUsiAdrs (iMUsiAdrs),
	.oSUsiAdrs (oSUsiAdrs),
	.oMUsiRd   (oMUsiRd)
);

`default_nettype wire

/* usibTop.sv */
`default_nettype none

module usibTop (
	input  wire logic               iSCLK,
	input  wire logic               iSRST,
	input  wire usibPkg::usibWord_t iMUsiAdrs,	// Master command word
	input  wire usibPkg::usibWord_t iMUsiWd,	// Master write data
	output wire usibPkg::usibWord_t oMUsiRd	// Read data, three cycles after command
);
	import usibPkg::*;

	// --------------------------------------------------
	// Interconnect wiring
	// --------------------------------------------------
	wire usibWord_t                       sUsiAdrs;	// Registered command to blocks
	wire usibWord_t                       sUsiWd;	// Registered write data
	wire logic [BLOCK_NUM*USIB_WIDTH-1:0] sUsiRdBus;	// One word slice per block

	usibRouter router_i (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iMUsiAdrs (iMUsiAdrs),
		.iMUsiWd   (iMUsiWd),
		.iSUsiRd   (sUsiRdBus),
		.oSUsiAdrs (sUsiAdrs),
		.oSUsiWd   (sUsiWd),
		.oMUsiRd   (oMUsiRd)
	);

	// --------------------------------------------------
	// Connected blocks
	// --------------------------------------------------
	for (genvar k = 0; k < BLOCK_NUM; k++)
	begin : gBlock
		wire logic      wrStrobe;
		wire logic      rdStrobe;
		wire csrIndex_t csrIndex;

		// Decode stage
		usibCmdDecode #(
			.pBlockIndex (k)
		) cmdDecode_i (
			.iSUsiAdrs (sUsiAdrs),
			.wrStrobe  (wrStrobe),
			.rdStrobe  (rdStrobe),
			.csrIndex  (csrIndex)
		);

		// Register bank, drives slice k of the read bus
		usibCsrBank #(
			.pBlockIndex (k)
		) csrBank_i (
			.iSCLK    (iSCLK),
			.iSRST    (iSRST),
			.wrStrobe (wrStrobe),
			.rdStrobe (rdStrobe),
			.csrIndex (csrIndex),
			.iSUsiWd  (sUsiWd),
			.oSUsiRd  (sUsiRdBus[k*USIB_WIDTH +: USIB_WIDTH])
		);
	end

endmodule

`default_nettype wire

/* usibCsrBank.sv */
`default_nettype none

module usibCsrBank #(
	parameter int pBlockIndex = 0	// Added to the identity base
) (
	input  wire logic               iSCLK,
	input  wire logic               iSRST,
	input  wire logic               wrStrobe,	// From the block's decoder
	input  wire logic               rdStrobe,
	input  wire usibPkg::csrIndex_t csrIndex,
	input  wire usibPkg::usibWord_t iSUsiWd,	// Forwarded write data
	output usibPkg::usibWord_t      oSUsiRd	// Read word, zero when not addressed
);
	import usibPkg::*;

	// Register 0 is not stored
	usibWord_t csrReg [1:CSR_DEPTH-1];
	usibWord_t idWord;
	usibWord_t wrMask;
	usibWord_t curWord;
	usibWord_t mergedWord;

	// --------------------------------------------------
	// Identity and write mask
	// --------------------------------------------------
	assign idWord = CSR_ID_BASE + usibWord_t'(pBlockIndex);

	// Mask of the addressed register
	assign wrMask = CSR_WRITE_MASK[csrIndex];

	// --------------------------------------------------
	// Current value of the addressed register
	// --------------------------------------------------
	always_comb
	begin
		curWord = idWord;	// Index 0
		for (int i = 1; i < CSR_DEPTH; i++)
		begin
			if (csrIndex == csrIndex_t'(i))
				curWord = csrReg[i];
		end
	end

	// New bits inside mask, old bits elsewhere
	assign mergedWord = (curWord & ~wrMask) | (iSUsiWd & wrMask);

	// --------------------------------------------------
	// Register writes
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			for (int i = 1; i < CSR_DEPTH; i++)
			begin
				csrReg[i] <= '0;
			end
		end
		else if (wrStrobe)
		begin
			for (int i = 1; i < CSR_DEPTH; i++)
			begin
				if (csrIndex == csrIndex_t'(i))
					csrReg[i] <= mergedWord;
			end
		end
	end

	// --------------------------------------------------
	// Read word
	// --------------------------------------------------
	// Same edge as a write, so a write-read sees the old value
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiRd <= '0;
		else if (rdStrobe)
			oSUsiRd <= curWord;
		else
			oSUsiRd <= '0;	// Unaddressed banks put zero on the bus
	end

endmodule

`default_nettype wire

/* usibCmdDecode.sv */
`default_nettype none

module usibCmdDecode #(
	parameter int pBlockIndex = 0	// Block number this decoder answers to
) (
	input  wire usibPkg::usibWord_t iSUsiAdrs,	// Forwarded command word
	output logic                    wrStrobe,
	output logic                    rdStrobe,
	output usibPkg::csrIndex_t      csrIndex	// Register inside the bank
);
	import usibPkg::*;

	usibCmd_t   cmd;
	blockAdrs_t blockAdrs;
	csrAdrs_t   csrAdrs;
	logic       blockHit;
	logic       adrsHit;
	logic       isWrite;
	logic       isRead;
	logic       regZero;

	// --------------------------------------------------
	// Field extraction
	// --------------------------------------------------
	assign cmd       = iSUsiAdrs[CMD_MSB:CMD_LSB];
	assign blockAdrs = iSUsiAdrs[BLOCK_LSB +: BLOCK_ADRS_WIDTH];
	assign csrAdrs   = iSUsiAdrs[CSR_ADRS_WIDTH-1:0];

	// Low address bits pick the register
	assign csrIndex = csrAdrs[CSR_INDEX_WIDTH-1:0];

	// --------------------------------------------------
	// Hit detection
	// --------------------------------------------------
	assign blockHit = (blockAdrs == blockAdrs_t'(pBlockIndex));

	// Addresses past the bank are not decoded
	assign adrsHit = (csrAdrs < csrAdrs_t'(CSR_DEPTH));

	// Write-read sets both
	always_comb
	begin
		isWrite = 1'b0;
		isRead  = 1'b0;
		case (cmd)
			CMD_WRITE:
			begin
				isWrite = 1'b1;
			end
			CMD_READ:
			begin
				isRead = 1'b1;
			end
			CMD_WRITE_READ:
			begin
				isWrite = 1'b1;
				isRead  = 1'b1;
			end
			default:
			begin
				isWrite = 1'b0;	// CMD_NONE
				isRead  = 1'b0;
			end
		endcase
	end

	assign regZero = (csrIndex == '0);	// Identity register

	// Identity takes reads only
	assign wrStrobe = blockHit && adrsHit && isWrite && !regZero;
	assign rdStrobe = blockHit && adrsHit && isRead;

endmodule

`default_nettype wire

/* usibRouter.sv */
`default_nettype none

module usibRouter (
	input  wire logic                                           iSCLK,
	input  wire logic                                           iSRST,
	input  wire usibPkg::usibWord_t                             iMUsiAdrs,	// Master command word
	input  wire usibPkg::usibWord_t                             iMUsiWd,	// Master write data
	input  wire logic [usibPkg::BLOCK_NUM*usibPkg::USIB_WIDTH-1:0] iSUsiRd,	// Block k at 32k+31:32k
	output usibPkg::usibWord_t                                  oSUsiAdrs,	// To every block
	output usibPkg::usibWord_t                                  oSUsiWd,
	output usibPkg::usibWord_t                                  oMUsiRd	// Back to master
);
	import usibPkg::*;

	blockAdrs_t blockDly;	// Block number, aligned with bank read word
	usibCmd_t   cmdDly;		// Command, same alignment
	usibWord_t  sUsiRd [BLOCK_NUM];
	usibWord_t  selWord;
	logic       blockInRange;
	logic       readDly;

	// --------------------------------------------------
	// Forward path to the blocks
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiAdrs <= '0;	// Command field back to CMD_NONE
		else
			oSUsiAdrs <= iMUsiAdrs;
	end

	always_ff @(posedge iSCLK)
	begin
		oSUsiWd <= iMUsiWd;	// Only meaningful with a write command
	end

	// Second stage, tracks the word the banks load
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			blockDly <= '0;
			cmdDly   <= CMD_NONE;
		end
		else
		begin
			blockDly <= oSUsiAdrs[BLOCK_LSB +: BLOCK_ADRS_WIDTH];
			cmdDly   <= oSUsiAdrs[CMD_MSB:CMD_LSB];
		end
	end

	// --------------------------------------------------
	// Read return selection
	// --------------------------------------------------
	// Split flat bus into one word per block
	for (genvar k = 0; k < BLOCK_NUM; k++)
	begin : gSplit
		assign sUsiRd[k] = iSUsiRd[k*USIB_WIDTH +: USIB_WIDTH];
	end

	assign blockInRange = blockDly < blockAdrs_t'(BLOCK_NUM);
	assign readDly      = (cmdDly == CMD_READ) || (cmdDly == CMD_WRITE_READ);

	always_comb
	begin
		selWord = '0;	// No match gives zero
		for (int k = 0; k < BLOCK_NUM; k++)
		begin
			if (blockDly == blockAdrs_t'(k))
				selWord = sUsiRd[k];
		end
	end

	// Read word to master, held between reads
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oMUsiRd <= '0;
		else if (!blockInRange)
			oMUsiRd <= '0;	// Nobody at this block number
		else if (readDly)
			oMUsiRd <= selWord;
	end

endmodule

`default_nettype wire

/* usibPkg.sv */
`default_nettype none

package usibPkg;

	// --------------------------------------------------
	// Bus and field widths
	// --------------------------------------------------
	localparam int USIB_WIDTH       = 32;	// Bus word width
	localparam int CSR_ADRS_WIDTH   = 16;	// CSR address field, bits 15:0
	localparam int BLOCK_ADRS_WIDTH = 5;	// Block number field, bits 20:16

	localparam int CMD_MSB   = 31;	// Command field top bit
	localparam int CMD_LSB   = 30;
	localparam int BLOCK_LSB = 16;	// Block number starts right above CSR address

	localparam int BLOCK_NUM       = 4;	// Connected blocks
	localparam int CSR_DEPTH       = 8;	// Registers per bank
	localparam int CSR_INDEX_WIDTH = $clog2(CSR_DEPTH);

	// --------------------------------------------------
	// Types
	// --------------------------------------------------
	typedef logic [USIB_WIDTH-1:0]        usibWord_t;
	typedef logic [CMD_MSB-CMD_LSB:0]     usibCmd_t;
	typedef logic [BLOCK_ADRS_WIDTH-1:0]  blockAdrs_t;
	typedef logic [CSR_ADRS_WIDTH-1:0]    csrAdrs_t;
	typedef logic [CSR_INDEX_WIDTH-1:0]   csrIndex_t;

	// Command codes in bits 31:30
	localparam usibCmd_t CMD_NONE       = 2'd0;	// Ignored by every block
	localparam usibCmd_t CMD_WRITE      = 2'd1;
	localparam usibCmd_t CMD_READ       = 2'd2;
	localparam usibCmd_t CMD_WRITE_READ = 2'd3;	// Read returns pre-write value

	// Identity register reads as base plus block index
	localparam usibWord_t CSR_ID_BASE = 32'hC5B0_0000;

	// Writable bits per register index
	localparam usibWord_t CSR_WRITE_MASK [CSR_DEPTH] = '{
		32'h0000_0000,	// Identity, read only
		32'hFFFF_FFFF,
		32'h0000_00FF,
		32'hFF00_FF00,
		32'h0FFF_FFF0,
		32'h8000_0001,
		32'h7FFF_FFFF,
		32'h0000_FFFF	// Low half only
	};

	// Command to read data, in clock edges
	localparam int READ_LATENCY = 3;

endpackage

`default_nettype wire
